// File: verilog/mgr_cfg_pkg.sv
package mgr_cfg_pkg;

    // Accelerator cluster
    localparam int NUM_ACCS = 8;
    localparam int NUM_TYPES = 2;

    // Type t owns accelerators t*ACCS_PER_TYPE up to t*ACCS_PER_TYPE+ACCS_PER_TYPE-1
    localparam int ACCS_PER_TYPE = 4;

    localparam int ACC_BITS = 3;

    // Command queue entries per accelerator, power of two
    localparam int SUBQUEUE_DEPTH = 4;

    // Outstanding children per creator
    localparam int CNT_BITS = 8;

    typedef logic [ACC_BITS-1:0] acc_id_t;

endpackage

// File: verilog/mgr_msg_pkg.sv
package mgr_msg_pkg;

    // New task word as sent on spawn_in
    typedef struct packed {
        logic [3:0]  task_type;
        logic [31:0] task_id;
        logic [27:0] arg;
    } spawn_desc_t;

    // Finish report word as sent on cmdout_in
    typedef struct packed {
        mgr_cfg_pkg::acc_id_t              creator;
        logic [31-mgr_cfg_pkg::ACC_BITS:0] reserved;
        logic [31:0]                       task_id;
    } finish_desc_t;

    // One accelerator word, meaning depends on the stream it arrives on
    typedef union packed {
        spawn_desc_t  spawn;
        finish_desc_t finish;
    } acc_word_u;

    typedef struct packed {
        mgr_cfg_pkg::acc_id_t creator;
        logic [31:0]          task_id;
        logic [27:0]          arg;
    } cmd_entry_t;

    typedef struct packed {
        logic                 valid;
        mgr_cfg_pkg::acc_id_t id;
        acc_word_u            data;
    } stream_in_t;

    typedef struct packed {
        logic                 valid;
        mgr_cfg_pkg::acc_id_t dest;
        logic [63:0]          data;
    } stream_out_t;

endpackage

// File: verilog/acc_scheduler.sv
module acc_scheduler (
    input  logic                                      aclk,
    input  logic                                      arst_n,
    input  logic [$clog2(mgr_cfg_pkg::NUM_TYPES)-1:0] sched_type,
    input  logic                                      sched_commit,
    output mgr_cfg_pkg::acc_id_t                      sched_acc
);

    // One pointer per type, wraps within the type's accelerators
    logic [$clog2(mgr_cfg_pkg::ACCS_PER_TYPE)-1:0] rr_ptr [mgr_cfg_pkg::NUM_TYPES];

    assign sched_acc = mgr_cfg_pkg::acc_id_t'(int'(sched_type) * mgr_cfg_pkg::ACCS_PER_TYPE
                                              + int'(rr_ptr[sched_type]));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < mgr_cfg_pkg::NUM_TYPES; t++) begin
                rr_ptr[t] <= '0;
            end
        end else if (sched_commit) begin
            rr_ptr[sched_type] <= rr_ptr[sched_type] + 1'b1;
        end
    end

endmodule

// File: verilog/cmdin_queue.sv
module cmdin_queue (
    input  logic                             aclk,
    input  logic                             arst_n,
    input  logic                             push_valid,
    input  mgr_cfg_pkg::acc_id_t             push_acc,
    input  mgr_msg_pkg::cmd_entry_t          push_entry,
    output logic [mgr_cfg_pkg::NUM_ACCS-1:0] full,
    output mgr_msg_pkg::stream_out_t         cmdin_out,
    input  logic                             cmdin_out_ready
);

    mgr_msg_pkg::cmd_entry_t mem [mgr_cfg_pkg::NUM_ACCS][mgr_cfg_pkg::SUBQUEUE_DEPTH];

    logic [$clog2(mgr_cfg_pkg::SUBQUEUE_DEPTH)-1:0] wr_ptr [mgr_cfg_pkg::NUM_ACCS];
    logic [$clog2(mgr_cfg_pkg::SUBQUEUE_DEPTH)-1:0] rd_ptr [mgr_cfg_pkg::NUM_ACCS];
    logic [$clog2(mgr_cfg_pkg::SUBQUEUE_DEPTH):0]   count  [mgr_cfg_pkg::NUM_ACCS];

    logic [mgr_cfg_pkg::NUM_ACCS-1:0] push_hit;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] pop_hit;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] wr_en;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] avail;

    mgr_cfg_pkg::acc_id_t    last_q;
    mgr_cfg_pkg::acc_id_t    sel;
    logic                    sel_ok;
    logic                    load;
    mgr_msg_pkg::cmd_entry_t head;

    logic                    out_valid;
    mgr_cfg_pkg::acc_id_t    out_dest;
    mgr_msg_pkg::cmd_entry_t out_entry;

    // A push into an empty queue counts as available in the same cycle
    always_comb begin
        for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
            push_hit[i] = push_valid && (push_acc == mgr_cfg_pkg::acc_id_t'(i));
            avail[i]    = (count[i] != '0) || push_hit[i];
            full[i]     = (count[i] == mgr_cfg_pkg::SUBQUEUE_DEPTH);
            pop_hit[i]  = load && (sel == mgr_cfg_pkg::acc_id_t'(i));
            wr_en[i]    = push_hit[i] && !(pop_hit[i] && count[i] == '0);
        end
    end

    // Round-robin, search starts after the last served queue
    always_comb begin
        mgr_cfg_pkg::acc_id_t idx;
        sel    = last_q;
        sel_ok = 1'b0;
        for (int k = 1; k <= mgr_cfg_pkg::NUM_ACCS; k++) begin
            idx = mgr_cfg_pkg::acc_id_t'((int'(last_q) + k) % mgr_cfg_pkg::NUM_ACCS);
            if (!sel_ok && avail[idx]) begin
                sel    = idx;
                sel_ok = 1'b1;
            end
        end
    end

    assign load = sel_ok && (!out_valid || cmdin_out_ready);
    assign head = (count[sel] != '0) ? mem[sel][rd_ptr[sel]] : push_entry;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
            last_q    <= '0;
            out_valid <= 1'b0;
        end else begin
            for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
                if (wr_en[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (pop_hit[i] && count[i] != '0) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                case ({push_hit[i], pop_hit[i]})
                    2'b10:   count[i] <= count[i] + 1'b1;
                    2'b01:   count[i] <= count[i] - 1'b1;
                    default: count[i] <= count[i];
                endcase
            end
            if (load) begin
                out_valid <= 1'b1;
                last_q    <= sel;
            end else if (cmdin_out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
            if (wr_en[i]) begin
                mem[i][wr_ptr[i]] <= push_entry;
            end
        end
        if (load) begin
            out_dest  <= sel;
            out_entry <= head;
        end
    end

    assign cmdin_out.valid = out_valid;
    assign cmdin_out.dest  = out_dest;
    assign cmdin_out.data  = 64'(out_entry);

    assert property (@(posedge aclk) disable iff (!arst_n)
        push_valid |-> !full[push_acc])
    else $error("push into full command queue %0d", push_acc);

endmodule

// File: verilog/taskwait_tracker.sv
module taskwait_tracker (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     child_inc,
    input  mgr_cfg_pkg::acc_id_t     child_creator,
    input  mgr_msg_pkg::stream_in_t  cmdout_in,
    output logic                     cmdout_in_ready,
    input  mgr_msg_pkg::stream_in_t  taskwait_in,
    output logic                     taskwait_in_ready,
    output mgr_msg_pkg::stream_out_t taskwait_out,
    input  logic                     taskwait_out_ready
);

    logic [mgr_cfg_pkg::CNT_BITS-1:0] count [mgr_cfg_pkg::NUM_ACCS];

    logic [mgr_cfg_pkg::NUM_ACCS-1:0] pending;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] inc_hit;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] dec_hit;

    mgr_msg_pkg::finish_desc_t fin;
    logic                      fin_ready;
    logic                      fin_take;
    logic                      tw_take;

    mgr_cfg_pkg::acc_id_t ack_sel;
    logic                 ack_any;
    logic                 ack_load;
    logic                 ack_valid;
    mgr_cfg_pkg::acc_id_t ack_dest;

    assign fin      = cmdout_in.data.finish;
    assign fin_take = cmdout_in.valid && fin_ready;

    assign cmdout_in_ready   = fin_ready;
    assign taskwait_in_ready = !pending[taskwait_in.id];
    assign tw_take           = taskwait_in.valid && taskwait_in_ready;

    // Lowest creator with a pending wait and no children left
    always_comb begin
        ack_sel = '0;
        ack_any = 1'b0;
        for (int i = mgr_cfg_pkg::NUM_ACCS - 1; i >= 0; i--) begin
            inc_hit[i] = child_inc && (child_creator == mgr_cfg_pkg::acc_id_t'(i));
            dec_hit[i] = fin_take && (fin.creator == mgr_cfg_pkg::acc_id_t'(i));
            if (pending[i] && count[i] == '0) begin
                ack_sel = mgr_cfg_pkg::acc_id_t'(i);
                ack_any = 1'b1;
            end
        end
    end

    assign ack_load = ack_any && (!ack_valid || taskwait_out_ready);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
                count[i] <= '0;
            end
            pending   <= '0;
            fin_ready <= 1'b0;
            ack_valid <= 1'b0;
        end else begin
            fin_ready <= 1'b1;
            // New child and finish on one creator cancel out
            for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
                case ({inc_hit[i], dec_hit[i]})
                    2'b10:   count[i] <= count[i] + 1'b1;
                    2'b01:   count[i] <= count[i] - 1'b1;
                    default: count[i] <= count[i];
                endcase
            end
            if (tw_take) begin
                pending[taskwait_in.id] <= 1'b1;
            end
            if (ack_load) begin
                pending[ack_sel] <= 1'b0;
                ack_valid        <= 1'b1;
            end else if (taskwait_out_ready) begin
                ack_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ack_load) begin
            ack_dest <= ack_sel;
        end
    end

    assign taskwait_out.valid = ack_valid;
    assign taskwait_out.dest  = ack_dest;
    assign taskwait_out.data  = '0;

    // Finish report for a creator with no counted children
    assert property (@(posedge aclk) disable iff (!arst_n)
        (fin_take && !(child_inc && child_creator == fin.creator))
            |-> count[fin.creator] != '0)
    else $error("child counter underflow for creator %0d", fin.creator);

endmodule

// File: verilog/mgr_control.sv
module mgr_control (
    input  logic                                      aclk,
    input  logic                                      arst_n,
    input  mgr_msg_pkg::stream_in_t                   spawn_in,
    output logic                                      spawn_in_ready,
    output mgr_msg_pkg::stream_out_t                  spawn_out,
    input  logic                                      spawn_out_ready,
    output logic [$clog2(mgr_cfg_pkg::NUM_TYPES)-1:0] sched_type,
    output logic                                      sched_commit,
    input  mgr_cfg_pkg::acc_id_t                      sched_acc,
    output logic                                      push_valid,
    output mgr_cfg_pkg::acc_id_t                      push_acc,
    output mgr_msg_pkg::cmd_entry_t                   push_entry,
    input  logic [mgr_cfg_pkg::NUM_ACCS-1:0]          full,
    output logic                                      child_inc,
    output mgr_cfg_pkg::acc_id_t                      child_creator
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        ACK
    } state_t;

    state_t                state;
    mgr_msg_pkg::acc_word_u word_q;
    mgr_cfg_pkg::acc_id_t   creator_q;
    mgr_cfg_pkg::acc_id_t   ack_acc_q;
    logic                   issue_go;

    // Wait for room in the chosen queue
    assign issue_go = (state == ISSUE) && !full[sched_acc];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (spawn_in.valid) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue_go) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (spawn_out_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (spawn_in.valid && spawn_in_ready) begin
            creator_q <= spawn_in.id;
            word_q    <= spawn_in.data;
        end
        if (issue_go) begin
            ack_acc_q <= sched_acc;
        end
    end

    assign spawn_in_ready = (state == IDLE);

    assign sched_type   = word_q.spawn.task_type[$clog2(mgr_cfg_pkg::NUM_TYPES)-1:0];
    assign sched_commit = issue_go;

    assign push_valid         = issue_go;
    assign push_acc           = sched_acc;
    assign push_entry.creator = creator_q;
    assign push_entry.task_id = word_q.spawn.task_id;
    assign push_entry.arg     = word_q.spawn.arg;

    assign child_inc     = issue_go;
    assign child_creator = creator_q;

    // Ack carries the task id high and the assigned accelerator low
    assign spawn_out.valid = (state == ACK);
    assign spawn_out.dest  = creator_q;
    assign spawn_out.data  = {word_q.spawn.task_id,
                              {(32 - mgr_cfg_pkg::ACC_BITS){1'b0}},
                              ack_acc_q};

    // Target must belong to the requested type
    assert property (@(posedge aclk) disable iff (!arst_n)
        sched_commit |-> int'(sched_acc) / mgr_cfg_pkg::ACCS_PER_TYPE == int'(sched_type))
    else $error("scheduler chose accelerator %0d outside type %0d", sched_acc, sched_type);

endmodule

// File: verilog/task_manager.sv
module task_manager (
    input  logic                     aclk,
    input  logic                     arst_n,
    // Task creation
    input  mgr_msg_pkg::stream_in_t  spawn_in,
    output logic                     spawn_in_ready,
    output mgr_msg_pkg::stream_out_t spawn_out,
    input  logic                     spawn_out_ready,
    // Commands to accelerators
    output mgr_msg_pkg::stream_out_t cmdin_out,
    input  logic                     cmdin_out_ready,
    // Finish reports
    input  mgr_msg_pkg::stream_in_t  cmdout_in,
    output logic                     cmdout_in_ready,
    // Taskwait
    input  mgr_msg_pkg::stream_in_t  taskwait_in,
    output logic                     taskwait_in_ready,
    output mgr_msg_pkg::stream_out_t taskwait_out,
    input  logic                     taskwait_out_ready
);

    logic [$clog2(mgr_cfg_pkg::NUM_TYPES)-1:0] sched_type;
    logic                                      sched_commit;
    mgr_cfg_pkg::acc_id_t                      sched_acc;

    logic                            push_valid;
    mgr_cfg_pkg::acc_id_t            push_acc;
    mgr_msg_pkg::cmd_entry_t         push_entry;
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] full;

    logic                 child_inc;
    mgr_cfg_pkg::acc_id_t child_creator;

    mgr_control mgr_control_inst (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .spawn_in        (spawn_in),
        .spawn_in_ready  (spawn_in_ready),
        .spawn_out       (spawn_out),
        .spawn_out_ready (spawn_out_ready),
        .sched_type      (sched_type),
        .sched_commit    (sched_commit),
        .sched_acc       (sched_acc),
        .push_valid      (push_valid),
        .push_acc        (push_acc),
        .push_entry      (push_entry),
        .full            (full),
        .child_inc       (child_inc),
        .child_creator   (child_creator)
    );

    acc_scheduler acc_scheduler_inst (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .sched_type   (sched_type),
        .sched_commit (sched_commit),
        .sched_acc    (sched_acc)
    );

    cmdin_queue cmdin_queue_inst (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .push_valid      (push_valid),
        .push_acc        (push_acc),
        .push_entry      (push_entry),
        .full            (full),
        .cmdin_out       (cmdin_out),
        .cmdin_out_ready (cmdin_out_ready)
    );

    taskwait_tracker taskwait_tracker_inst (
        .aclk               (aclk),
        .arst_n             (arst_n),
        .child_inc          (child_inc),
        .child_creator      (child_creator),
        .cmdout_in          (cmdout_in),
        .cmdout_in_ready    (cmdout_in_ready),
        .taskwait_in        (taskwait_in),
        .taskwait_in_ready  (taskwait_in_ready),
        .taskwait_out       (taskwait_out),
        .taskwait_out_ready (taskwait_out_ready)
    );

endmodule

// File: sim/tb_task_manager.sv
module tb_task_manager;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_SPAWNS = 200;
    localparam int MAX_CYCLES = 40 * N_SPAWNS + 2000;
    localparam int STALL_AT = 60;
    localparam int STALL_LEN = 150;

    logic aclk = 1'b0;
    logic arst_n;

    mgr_msg_pkg::stream_in_t  spawn_in;
    mgr_msg_pkg::stream_in_t  cmdout_in;
    mgr_msg_pkg::stream_in_t  taskwait_in;
    mgr_msg_pkg::stream_out_t spawn_out;
    mgr_msg_pkg::stream_out_t cmdin_out;
    mgr_msg_pkg::stream_out_t taskwait_out;
    logic spawn_in_ready;
    logic spawn_out_ready;
    logic cmdin_out_ready;
    logic cmdout_in_ready;
    logic taskwait_in_ready;
    logic taskwait_out_ready;

    // Reference model
    mgr_msg_pkg::cmd_entry_t exp_q [mgr_cfg_pkg::NUM_ACCS][N_SPAWNS];
    int exp_wr [mgr_cfg_pkg::NUM_ACCS] = '{default: 0};
    int exp_rd [mgr_cfg_pkg::NUM_ACCS] = '{default: 0};
    int rr_ptr [mgr_cfg_pkg::NUM_TYPES] = '{default: 0};
    int child_cnt [mgr_cfg_pkg::NUM_ACCS] = '{default: 0};
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] wait_open = '0;
    mgr_cfg_pkg::acc_id_t exp_ack_dest;
    mgr_cfg_pkg::acc_id_t exp_ack_acc;
    logic [31:0]          exp_ack_id;

    // Stimulus state
    logic [mgr_cfg_pkg::NUM_ACCS-1:0] tw_busy = '0;
    logic sp_busy = 1'b0;
    logic tw_issued = 1'b0;
    logic final_waits = 1'b0;
    logic stall_done = 1'b0;
    logic hold_seen = 1'b0;
    int   stall_left = 0;
    int   ack_wait = 0;
    int   tw_seq = 0;
    int   spawns_sent = 0;
    int   spawns_acked = 0;
    int   fins_sent = 0;
    int   cycle = 0;
    int   mismatches = 0;
    int   other_errors = 0;
    mgr_msg_pkg::finish_desc_t fin_word [$];
    int fin_due [$];

    logic sp_fire;
    logic sa_fire;
    logic cmd_fire;
    logic fin_fire;
    logic tw_fire;
    logic twa_fire;

    assign sp_fire  = spawn_in.valid && spawn_in_ready;
    assign sa_fire  = spawn_out.valid && spawn_out_ready;
    assign cmd_fire = cmdin_out.valid && cmdin_out_ready;
    assign fin_fire = cmdout_in.valid && cmdout_in_ready;
    assign tw_fire  = taskwait_in.valid && taskwait_in_ready;
    assign twa_fire = taskwait_out.valid && taskwait_out_ready;

    task_manager task_manager_inst (
        .aclk               (aclk),
        .arst_n             (arst_n),
        .spawn_in           (spawn_in),
        .spawn_in_ready     (spawn_in_ready),
        .spawn_out          (spawn_out),
        .spawn_out_ready    (spawn_out_ready),
        .cmdin_out          (cmdin_out),
        .cmdin_out_ready    (cmdin_out_ready),
        .cmdout_in          (cmdout_in),
        .cmdout_in_ready    (cmdout_in_ready),
        .taskwait_in        (taskwait_in),
        .taskwait_in_ready  (taskwait_in_ready),
        .taskwait_out       (taskwait_out),
        .taskwait_out_ready (taskwait_out_ready)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        int t;
        mgr_cfg_pkg::acc_id_t acc;
        if (sp_fire) begin
            // Round-robin within the requested type
            t = int'(spawn_in.data.spawn.task_type);
            acc = mgr_cfg_pkg::acc_id_t'(t * mgr_cfg_pkg::ACCS_PER_TYPE + rr_ptr[t]);
            rr_ptr[t] <= (rr_ptr[t] + 1) % mgr_cfg_pkg::ACCS_PER_TYPE;
            exp_q[acc][exp_wr[acc]] <= '{creator: spawn_in.id,
                                         task_id: spawn_in.data.spawn.task_id,
                                         arg:     spawn_in.data.spawn.arg};
            exp_wr[acc]  <= exp_wr[acc] + 1;
            exp_ack_dest <= spawn_in.id;
            exp_ack_acc  <= acc;
            exp_ack_id   <= spawn_in.data.spawn.task_id;
            spawns_sent  <= spawns_sent + 1;
        end
        if (sa_fire) begin
            spawns_acked <= spawns_acked + 1;
        end
        if (cmd_fire) begin
            exp_rd[cmdin_out.dest] <= exp_rd[cmdin_out.dest] + 1;
        end
        if (fin_fire) begin
            fins_sent <= fins_sent + 1;
        end
        for (int i = 0; i < mgr_cfg_pkg::NUM_ACCS; i++) begin
            child_cnt[i] <= child_cnt[i] + int'(sp_fire && spawn_in.id == i)
                            - int'(fin_fire && cmdout_in.data.finish.creator == i);
        end
        if (tw_fire) begin
            wait_open[taskwait_in.id] <= 1'b1;
        end
        if (twa_fire) begin
            wait_open[taskwait_out.dest] <= 1'b0;
        end
    end

    // Creators: one spawn in flight, and no spawn from a creator that waits
    always @(posedge aclk) begin
        mgr_cfg_pkg::acc_id_t c;
        mgr_cfg_pkg::acc_id_t sp_c;
        logic sp_new;
        sp_new = 1'b0;
        sp_c = '0;
        if (sp_fire) begin
            spawn_in.valid <= 1'b0;
        end
        if (sa_fire) begin
            sp_busy <= 1'b0;
        end
        if (arst_n && tw_issued && !sp_busy && spawns_sent < N_SPAWNS
                && $urandom_range(2) == 0) begin
            sp_c = mgr_cfg_pkg::acc_id_t'($urandom_range(mgr_cfg_pkg::NUM_ACCS - 1));
            if (!tw_busy[sp_c]) begin
                sp_new = 1'b1;
                sp_busy <= 1'b1;
                spawn_in.valid <= 1'b1;
                spawn_in.id <= sp_c;
                spawn_in.data.spawn.task_type <= (stall_left > 0) ? 4'd0 : 4'($urandom_range(1));
                spawn_in.data.spawn.task_id <= {16'($urandom), 16'(spawns_sent)};
                spawn_in.data.spawn.arg <= 28'($urandom);
            end
        end
        if (tw_fire) begin
            taskwait_in.valid <= 1'b0;
        end
        if (twa_fire) begin
            tw_busy[taskwait_out.dest] <= 1'b0;
        end
        // No random waits in the drain stall, creators stay free to spawn
        if (arst_n && !taskwait_in.valid && (!tw_issued || (final_waits
                ? tw_seq < mgr_cfg_pkg::NUM_ACCS
                : stall_left == 0 && $urandom_range(15) == 0))) begin
            c = final_waits ? mgr_cfg_pkg::acc_id_t'(tw_seq)
                            : mgr_cfg_pkg::acc_id_t'($urandom_range(mgr_cfg_pkg::NUM_ACCS - 1));
            if (!tw_busy[c] && !(sp_busy && spawn_in.id == c) && !(sp_new && sp_c == c)) begin
                taskwait_in.valid <= 1'b1;
                taskwait_in.id <= c;
                taskwait_in.data <= 64'({$urandom, $urandom});
                tw_busy[c] <= 1'b1;
                tw_issued <= 1'b1;
                if (final_waits) begin
                    tw_seq <= tw_seq + 1;
                end
            end
        end
    end

    // Accelerators report each command back after a random delay
    always @(posedge aclk) begin
        int k;
        mgr_msg_pkg::finish_desc_t fw;
        k = -1;
        if (cmd_fire) begin
            fw.creator  = cmdin_out.data[62:60];
            fw.reserved = '0;
            fw.task_id  = cmdin_out.data[59:28];
            fin_word.push_back(fw);
            fin_due.push_back(cycle + int'($urandom_range(30, 1)));
        end
        if (fin_fire) begin
            cmdout_in.valid <= 1'b0;
        end else if (!cmdout_in.valid) begin
            foreach (fin_due[i]) begin
                if (k < 0 && fin_due[i] <= cycle) begin
                    k = i;
                end
            end
            if (k >= 0) begin
                cmdout_in.valid <= 1'b1;
                cmdout_in.id <= fin_word[k].creator;
                cmdout_in.data.finish <= fin_word[k];
                fin_word.delete(k);
                fin_due.delete(k);
            end
        end
    end

    always @(posedge aclk) begin
        if (arst_n) begin
            spawn_out_ready <= ($urandom_range(3) != 0);
            taskwait_out_ready <= ($urandom_range(3) != 0);
            cmdin_out_ready <= (stall_left == 0) && ($urandom_range(3) != 0);
        end
        // One long drain stall while spawns target type 0 only
        if (stall_left > 0) begin
            stall_left <= stall_left - 1;
        end else if (!stall_done && spawns_sent == STALL_AT) begin
            stall_left <= STALL_LEN;
            stall_done <= 1'b1;
        end
        // Ack still missing two cycles after acceptance means a full queue
        if (sp_fire) begin
            ack_wait <= 1;
        end else if (spawn_out.valid) begin
            ack_wait <= 0;
        end else if (ack_wait > 0) begin
            ack_wait <= ack_wait + 1;
        end
        if (stall_left > 0 && ack_wait > 2) begin
            hold_seen <= 1'b1;
        end
    end

    assert property (@(posedge aclk) $rose(arst_n)
        |-> !spawn_out.valid && !cmdin_out.valid && !taskwait_out.valid)
    else begin
        mismatches++;
        $display("MISMATCH %0t: a valid output is high right after reset", $time);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        $past(arst_n) |-> cmdout_in_ready)
    else begin
        mismatches++;
        $display("MISMATCH %0t: cmdout_in_ready low after reset", $time);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        sa_fire |-> spawn_out.dest == exp_ack_dest && spawn_out.data[63:32] == exp_ack_id
            && spawn_out.data[31:3] == '0 && spawn_out.data[2:0] == exp_ack_acc)
    else begin
        mismatches++;
        $display("MISMATCH %0t: spawn ack dest %0d data %h, expected dest %0d acc %0d id %h",
                 $time, spawn_out.dest, spawn_out.data, exp_ack_dest, exp_ack_acc, exp_ack_id);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        spawn_out.valid && !spawn_out_ready |=> spawn_out.valid && $stable(spawn_out))
    else begin
        mismatches++;
        $display("MISMATCH %0t: spawn ack changed while held back", $time);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        spawn_out.valid |-> !spawn_in_ready)
    else begin
        mismatches++;
        $display("MISMATCH %0t: spawn_in_ready high while an ack is pending", $time);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        cmd_fire |-> exp_rd[cmdin_out.dest] < exp_wr[cmdin_out.dest]
            && cmdin_out.data == 64'(exp_q[cmdin_out.dest][exp_rd[cmdin_out.dest]]))
    else begin
        mismatches++;
        $display("MISMATCH %0t: command %h to accelerator %0d is not the queue head",
                 $time, cmdin_out.data, cmdin_out.dest);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        taskwait_in.valid && !wait_open[taskwait_in.id] |-> taskwait_in_ready)
    else begin
        mismatches++;
        $display("MISMATCH %0t: taskwait from creator %0d refused with no wait pending",
                 $time, taskwait_in.id);
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        twa_fire |-> wait_open[taskwait_out.dest] && child_cnt[taskwait_out.dest] == 0
            && taskwait_out.data == '0)
    else begin
        mismatches++;
        $display("MISMATCH %0t: taskwait ack to creator %0d, open %b, children %0d", $time,
                 taskwait_out.dest, wait_open[taskwait_out.dest], child_cnt[taskwait_out.dest]);
    end

    task automatic report_and_stop();
        $display("errors: mismatches=%0d other=%0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d of %0d spawns acknowledged",
                     cycle, spawns_acked, N_SPAWNS);
            report_and_stop();
        end
    end

    initial begin
        int seed;
        seed = $urandom(20668);
        arst_n = 1'b0;
        spawn_in = '0;
        cmdout_in = '0;
        taskwait_in = '0;
        spawn_out_ready = 1'b0;
        cmdin_out_ready = 1'b0;
        taskwait_out_ready = 1'b0;
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;
        while (spawns_acked < N_SPAWNS || fins_sent < N_SPAWNS) begin
            @(posedge aclk);
        end
        final_waits <= 1'b1;
        @(posedge aclk);
        while (tw_seq < mgr_cfg_pkg::NUM_ACCS || tw_busy != '0) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
        for (int a = 0; a < mgr_cfg_pkg::NUM_ACCS; a++) begin
            assert (exp_rd[a] == exp_wr[a]) else begin
                other_errors++;
                $display("accelerator %0d never received %0d queued commands",
                         a, exp_wr[a] - exp_rd[a]);
            end
        end
        assert (wait_open == '0) else begin
            other_errors++;
            $display("wait requests left without an acknowledge: %b", wait_open);
        end
        assert (hold_seen) else begin
            other_errors++;
            $display("the drain stall never held a spawn back on full queues");
        end
        report_and_stop();
    end

endmodule

// File: files.f
verilog/mgr_cfg_pkg.sv
verilog/mgr_msg_pkg.sv
verilog/acc_scheduler.sv
verilog/cmdin_queue.sv
verilog/taskwait_tracker.sv
verilog/mgr_control.sv
verilog/task_manager.sv
sim/tb_task_manager.sv

// File: Bender.yml
package:
  name: task_manager

sources:
  - files:
      - verilog/mgr_cfg_pkg.sv
      - verilog/mgr_msg_pkg.sv
      - verilog/acc_scheduler.sv
      - verilog/cmdin_queue.sv
      - verilog/taskwait_tracker.sv
      - verilog/mgr_control.sv
      - verilog/task_manager.sv
  - target: simulation
    files:
      - sim/tb_task_manager.sv
